// ==== mcu_bridge.f ====
+incdir+.
mcu_pkg.sv
mcu_spi_slave.sv
mcu_protocol.sv
mcu_registers.sv
mem_transfer.sv
mcu_bridge.sv
tb_mcu_bridge.sv

// ==== mcu_bridge.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "mcu_bridge_consts.svh"

module mcu_bridge import mcu_pkg::*; (
    input logic clk,
    input logic reset,
    input logic mcu_clk,
    input logic mcu_cs,
    input logic mcu_mosi,
    output logic mcu_miso,
    input logic sd_det,
    input logic button,
    output logic mem_request,
    input logic mem_ack,
    output logic mem_write,
    output logic [`MEM_ADDR_W-1:0] mem_address,
    output mem_word_t mem_wdata,
    input mem_word_t mem_rdata
);

    logic frame_start;
    logic data_ready;
    logic [`MCU_BYTE_W-1:0] rx_data;
    logic [`MCU_BYTE_W-1:0] tx_data;

    logic reg_read;
    logic reg_write;
    reg_address_e reg_address;
    reg_word_t reg_wdata;
    reg_word_t reg_rdata;

    logic buf_read;
    logic buf_write;
    buf_index_t buf_index;
    mem_word_t buf_wdata;
    mem_word_t buf_rdata;

    logic xfer_start;
    logic xfer_stop;
    logic xfer_write;
    buf_index_t xfer_length;
    logic [`MEM_ADDR_W-1:0] xfer_address;
    logic mem_busy;

    mcu_spi_slave spi_i (
        .clk(clk),
        .reset(reset),
        .mcu_clk(mcu_clk),
        .mcu_cs(mcu_cs),
        .mcu_mosi(mcu_mosi),
        .tx_data(tx_data),
        .mcu_miso(mcu_miso),
        .frame_start(frame_start),
        .data_ready(data_ready),
        .rx_data(rx_data)
    );

    mcu_protocol protocol_i (
        .clk(clk),
        .reset(reset),
        .frame_start(frame_start),
        .data_ready(data_ready),
        .rx_data(rx_data),
        .reg_rdata(reg_rdata),
        .buf_rdata(buf_rdata),
        .tx_data(tx_data),
        .reg_read(reg_read),
        .reg_write(reg_write),
        .reg_address(reg_address),
        .reg_wdata(reg_wdata),
        .buf_read(buf_read),
        .buf_write(buf_write),
        .buf_index(buf_index),
        .buf_wdata(buf_wdata)
    );

    mcu_registers registers_i (
        .clk(clk),
        .reset(reset),
        .reg_read(reg_read),
        .reg_write(reg_write),
        .reg_address(reg_address),
        .reg_wdata(reg_wdata),
        .mem_busy(mem_busy),
        .sd_det(sd_det),
        .button(button),
        .reg_rdata(reg_rdata),
        .xfer_start(xfer_start),
        .xfer_stop(xfer_stop),
        .xfer_write(xfer_write),
        .xfer_length(xfer_length),
        .xfer_address(xfer_address)
    );

    mem_transfer transfer_i (
        .clk(clk),
        .reset(reset),
        .buf_read(buf_read),
        .buf_write(buf_write),
        .buf_index(buf_index),
        .buf_wdata(buf_wdata),
        .xfer_start(xfer_start),
        .xfer_stop(xfer_stop),
        .xfer_write(xfer_write),
        .xfer_length(xfer_length),
        .xfer_address(xfer_address),
        .mem_ack(mem_ack),
        .mem_rdata(mem_rdata),
        .buf_rdata(buf_rdata),
        .mem_busy(mem_busy),
        .mem_request(mem_request),
        .mem_write(mem_write),
        .mem_address(mem_address),
        .mem_wdata(mem_wdata)
    );

endmodule

`default_nettype wire

// ==== mcu_bridge_consts.svh ====
`ifndef MCU_BRIDGE_CONSTS_SVH
`define MCU_BRIDGE_CONSTS_SVH

`define MCU_BYTE_W      8
`define REG_DATA_W      32
`define MEM_DATA_W      16
`define MEM_ADDR_W      32
`define MEM_BUF_DEPTH   512
`define MEM_BUF_IDX_W   9
`define MCU_FPGA_ID     8'h64
`define MCU_CHIP_ID     32'h53437632
`define SYNC_STAGES     3

// memory control register fields
`define MEM_SCR_START   0
`define MEM_SCR_STOP    1
`define MEM_SCR_DIR     2
`define MEM_SCR_BUSY    3
`define MEM_SCR_LEN_LSB 5
`define MEM_SCR_LEN_MSB 14

`endif

// ==== mcu_pkg.sv ====
`default_nettype none

package mcu_pkg;

`include "mcu_bridge_consts.svh"

    typedef enum logic [7:0] {
        CMD_IDENTIFY  = 8'd0,
        CMD_REG_READ  = 8'd1,
        CMD_REG_WRITE = 8'd2,
        CMD_BUF_READ  = 8'd3,
        CMD_BUF_WRITE = 8'd4
    } mcu_cmd_e;

    typedef enum logic [1:0] {
        PHASE_CMD,
        PHASE_ADDRESS,
        PHASE_DATA,
        PHASE_IDLE
    } mcu_phase_e;

    typedef enum logic [7:0] {
        REG_MEM_ADDRESS  = 8'd0,
        REG_MEM_SCR      = 8'd1,
        REG_INPUT_STATUS = 8'd2,
        REG_IDENTIFIER   = 8'd3
    } reg_address_e;

    typedef logic [`REG_DATA_W-1:0] reg_word_t;
    typedef logic [`MEM_DATA_W-1:0] mem_word_t;
    typedef logic [`MEM_BUF_IDX_W-1:0] buf_index_t;

endpackage

`default_nettype wire

// ==== mcu_protocol.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "mcu_bridge_consts.svh"

module mcu_protocol import mcu_pkg::*; (
    input logic clk,
    input logic reset,
    input logic frame_start,
    input logic data_ready,
    input logic [`MCU_BYTE_W-1:0] rx_data,
    input reg_word_t reg_rdata,
    input mem_word_t buf_rdata,
    output logic [`MCU_BYTE_W-1:0] tx_data,
    output logic reg_read,
    output logic reg_write,
    output reg_address_e reg_address,
    output reg_word_t reg_wdata,
    output logic buf_read,
    output logic buf_write,
    output buf_index_t buf_index,
    output mem_word_t buf_wdata
);

    mcu_phase_e phase;
    mcu_cmd_e cmd;
    logic [1:0] counter;   // byte within word
    logic word_select;

    assign buf_index = {reg_address, word_select};

    always_ff @(posedge clk) begin
        reg_read <= 1'b0;
        reg_write <= 1'b0;
        buf_read <= 1'b0;
        buf_write <= 1'b0;

        if (reset) begin
            phase <= PHASE_IDLE;
            cmd <= CMD_IDENTIFY;
            counter <= 2'd0;
            word_select <= 1'b0;
            reg_address <= REG_MEM_ADDRESS;
        end else begin
            if (frame_start) begin
                counter <= 2'd0;
                phase <= PHASE_CMD;
            end

            if (reg_read || reg_write || (word_select && (buf_read || buf_write))) begin
                reg_address <= reg_address_e'(reg_address + 8'd1);
            end

            if (data_ready) begin
                case (phase)
                    PHASE_CMD: begin
                        cmd <= mcu_cmd_e'(rx_data);
                        phase <= (rx_data > CMD_BUF_WRITE) ? PHASE_IDLE : PHASE_ADDRESS;
                    end

                    PHASE_ADDRESS: begin
                        reg_address <= reg_address_e'(rx_data);
                        phase <= PHASE_DATA;
                        reg_read <= (cmd == CMD_REG_READ);
                        if (cmd == CMD_BUF_READ) begin
                            buf_read <= 1'b1;
                            word_select <= 1'b0;
                        end
                    end

                    PHASE_DATA: begin
                        counter <= counter + 1'b1;
                        case (cmd)
                            CMD_REG_READ: reg_read <= (counter == 2'd3);
                            CMD_REG_WRITE: begin
                                reg_wdata[{counter, 3'b000} +: `MCU_BYTE_W] <= rx_data;
                                reg_write <= (counter == 2'd3);
                            end
                            CMD_BUF_READ: begin
                                if (counter[0]) begin
                                    buf_read <= 1'b1;
                                    word_select <= ~word_select;
                                end
                            end
                            CMD_BUF_WRITE: begin
                                if (counter[0]) begin
                                    buf_wdata[7:0] <= rx_data;
                                    buf_write <= 1'b1;
                                    word_select <= counter[1];
                                end else begin
                                    buf_wdata[15:8] <= rx_data;   // high byte first
                                end
                            end
                            default: ;
                        endcase
                    end

                    default: ;
                endcase
            end
        end
    end

    // ==========================================================
    // reply byte
    // ==========================================================

    always_comb begin
        tx_data = '0;
        if (phase == PHASE_ADDRESS && cmd == CMD_IDENTIFY) begin
            tx_data = `MCU_FPGA_ID;
        end
        if (phase == PHASE_DATA) begin
            case (cmd)
                CMD_IDENTIFY: tx_data = `MCU_FPGA_ID;
                CMD_REG_READ: tx_data = reg_rdata[{counter, 3'b000} +: `MCU_BYTE_W];   // lsb first
                CMD_BUF_READ: tx_data = counter[0] ? buf_rdata[7:0] : buf_rdata[15:8];
                default: tx_data = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== mcu_registers.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "mcu_bridge_consts.svh"

module mcu_registers import mcu_pkg::*; (
    input logic clk,
    input logic reset,
    input logic reg_read,
    input logic reg_write,
    input reg_address_e reg_address,
    input reg_word_t reg_wdata,
    input logic mem_busy,
    input logic sd_det,
    input logic button,
    output reg_word_t reg_rdata,
    output logic xfer_start,
    output logic xfer_stop,
    output logic xfer_write,
    output buf_index_t xfer_length,
    output logic [`MEM_ADDR_W-1:0] xfer_address
);

    logic [`SYNC_STAGES-1:0] sd_det_ff;
    logic [`SYNC_STAGES-1:0] button_ff;
    logic [`MEM_BUF_IDX_W:0] length_field;
    reg_word_t read_word;

    always_ff @(posedge clk) begin
        sd_det_ff <= {sd_det_ff[`SYNC_STAGES-2:0], sd_det};
        button_ff <= {button_ff[`SYNC_STAGES-2:0], button};
    end

    // ==========================================================
    // read side
    // ==========================================================

    always_comb begin
        read_word = '0;
        case (reg_address)
            REG_MEM_ADDRESS: read_word = xfer_address;
            REG_MEM_SCR: read_word[`MEM_SCR_BUSY] = mem_busy;
            REG_INPUT_STATUS: read_word[1:0] = {~button_ff[`SYNC_STAGES-1],
                                                ~sd_det_ff[`SYNC_STAGES-1]};   // active low pins
            REG_IDENTIFIER: read_word = `MCU_CHIP_ID;
            default: read_word = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reg_read) begin
            reg_rdata <= read_word;
        end
    end

    // ==========================================================
    // write side
    // ==========================================================

    assign length_field = reg_wdata[`MEM_SCR_LEN_MSB:`MEM_SCR_LEN_LSB] - 1'b1;

    always_ff @(posedge clk) begin
        xfer_start <= 1'b0;
        xfer_stop <= 1'b0;

        if (reset) begin
            xfer_write <= 1'b0;
        end else if (reg_write) begin
            case (reg_address)
                REG_MEM_ADDRESS: xfer_address <= reg_wdata;
                REG_MEM_SCR: begin
                    xfer_start <= reg_wdata[`MEM_SCR_START];
                    xfer_stop <= reg_wdata[`MEM_SCR_STOP];
                    xfer_write <= reg_wdata[`MEM_SCR_DIR];
                    xfer_length <= length_field[`MEM_BUF_IDX_W-1:0];   // index of last word
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== mcu_spi_slave.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "mcu_bridge_consts.svh"

module mcu_spi_slave (
    input logic clk,
    input logic reset,
    input logic mcu_clk,
    input logic mcu_cs,
    input logic mcu_mosi,
    input logic [`MCU_BYTE_W-1:0] tx_data,
    output logic mcu_miso,
    output logic frame_start,
    output logic data_ready,
    output logic [`MCU_BYTE_W-1:0] rx_data
);

    localparam int BIT_W = $clog2(`MCU_BYTE_W);
    localparam int NEW = `SYNC_STAGES - 2;   // newest settled stage
    localparam int OLD = `SYNC_STAGES - 1;

    logic [`SYNC_STAGES-1:0] sclk_ff;
    logic [`SYNC_STAGES-1:0] cs_ff;
    logic [`SYNC_STAGES-1:0] mosi_ff;

    logic [BIT_W-1:0] bit_count;
    logic [`MCU_BYTE_W-2:0] rx_shift;
    logic [`MCU_BYTE_W-1:0] tx_shift;

    logic sclk_rise;
    logic sclk_fall;
    logic cs_active;

    always_ff @(posedge clk) begin
        if (reset) begin
            sclk_ff <= '0;
            cs_ff <= '1;   // deselected
            mosi_ff <= '0;
        end else begin
            sclk_ff <= {sclk_ff[`SYNC_STAGES-2:0], mcu_clk};
            cs_ff <= {cs_ff[`SYNC_STAGES-2:0], mcu_cs};
            mosi_ff <= {mosi_ff[`SYNC_STAGES-2:0], mcu_mosi};
        end
    end

    assign sclk_rise = sclk_ff[NEW] && !sclk_ff[OLD];
    assign sclk_fall = !sclk_ff[NEW] && sclk_ff[OLD];
    assign cs_active = !cs_ff[NEW];

    always_ff @(posedge clk) begin
        frame_start <= 1'b0;
        data_ready <= 1'b0;

        if (reset) begin
            bit_count <= '0;
            mcu_miso <= 1'b0;
        end else begin
            frame_start <= cs_ff[OLD] && !cs_ff[NEW];
            mcu_miso <= (bit_count == '0) ? tx_data[`MCU_BYTE_W-1] : tx_shift[`MCU_BYTE_W-1];

            if (cs_ff[NEW] && !cs_ff[OLD]) begin
                bit_count <= '0;   // frame closed
            end else if (cs_active && sclk_rise) begin
                bit_count <= bit_count + 1'b1;
                rx_shift <= {rx_shift[`MCU_BYTE_W-3:0], mosi_ff[NEW]};
                if (bit_count == '0) begin
                    tx_shift <= tx_data;   // reply latched on first bit
                end
                if (bit_count == BIT_W'(`MCU_BYTE_W - 1)) begin
                    data_ready <= 1'b1;
                    rx_data <= {rx_shift, mosi_ff[NEW]};
                end
            end else if (cs_active && sclk_fall) begin
                tx_shift <= {tx_shift[`MCU_BYTE_W-2:0], 1'b0};
            end
        end
    end

endmodule

`default_nettype wire

// ==== mem_transfer.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "mcu_bridge_consts.svh"

module mem_transfer import mcu_pkg::*; (
    input logic clk,
    input logic reset,
    input logic buf_read,
    input logic buf_write,
    input buf_index_t buf_index,
    input mem_word_t buf_wdata,
    input logic xfer_start,
    input logic xfer_stop,
    input logic xfer_write,
    input buf_index_t xfer_length,
    input logic [`MEM_ADDR_W-1:0] xfer_address,
    input logic mem_ack,
    input mem_word_t mem_rdata,
    output mem_word_t buf_rdata,
    output logic mem_busy,
    output logic mem_request,
    output logic mem_write,
    output logic [`MEM_ADDR_W-1:0] mem_address,
    output mem_word_t mem_wdata
);

    mem_word_t buffer [0:`MEM_BUF_DEPTH-1];

    buf_index_t word_index;
    buf_index_t last_index;
    logic stop_pending;
    logic issue_word;
    logic store_word;

    assign issue_word = mem_busy && !mem_request;
    assign store_word = mem_busy && mem_request && mem_ack && !mem_write;

    // mcu port and engine port
    always_ff @(posedge clk) begin
        if (buf_write) begin
            buffer[buf_index] <= buf_wdata;
        end
        if (buf_read) begin
            buf_rdata <= buffer[buf_index];
        end
        if (store_word) begin
            buffer[word_index] <= mem_rdata;
        end
        if (issue_word) begin
            mem_wdata <= buffer[word_index];
        end
    end

    // ==========================================================
    // bus master
    // ==========================================================

    always_ff @(posedge clk) begin
        if (reset) begin
            mem_busy <= 1'b0;
            mem_request <= 1'b0;
            mem_write <= 1'b0;
            stop_pending <= 1'b0;
        end else begin
            if (xfer_stop) begin
                stop_pending <= mem_busy;   // idle stop is dropped
            end else if (xfer_start && !mem_busy) begin
                mem_write <= xfer_write;
                mem_address <= xfer_address;
                last_index <= xfer_length;
                word_index <= '0;
                mem_busy <= 1'b1;
            end

            if (issue_word) begin
                mem_request <= 1'b1;
            end

            if (mem_busy && mem_request && mem_ack) begin
                mem_request <= 1'b0;
                mem_address <= mem_address + 2'd2;
                word_index <= word_index + 1'b1;
                if (word_index == last_index || stop_pending) begin
                    mem_busy <= 1'b0;
                    stop_pending <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb_mcu_bridge.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "mcu_bridge_consts.svh"

module tb_mcu_bridge import mcu_pkg::*; ();

    localparam int HALF = 8;          // mcu_clk half-period in clk cycles
    localparam int POLL_LIMIT = 100;
    localparam int ACK_LIMIT = 1000;
    localparam int WRITE_WORDS = 512;
    localparam int READ_WORDS = 8;
    localparam int STOP_WORDS = 500;

    logic clk;
    logic reset;
    logic mcu_clk;
    logic mcu_cs;
    logic mcu_mosi;
    logic mcu_miso;
    logic sd_det;
    logic button;
    logic mem_request;
    logic mem_ack;
    logic mem_write;
    logic [`MEM_ADDR_W-1:0] mem_address;
    mem_word_t mem_wdata;
    mem_word_t mem_rdata;

    int checks;
    int errors;
    int timeouts;
    logic [31:0] stim_state;
    logic [31:0] delay_state;
    mem_word_t word_data [0:`MEM_BUF_DEPTH-1];
    mem_word_t word_read [0:`MEM_BUF_DEPTH-1];
    reg_word_t reg_words [0:3];

    // memory model tagged with the full address of each stored word
    mem_word_t mem_model [0:1023];
    logic [31:0] mem_owner [0:1023];
    logic mem_valid [0:1023];
    int req_count;
    logic [31:0] log_address [0:1023];
    mem_word_t log_data [0:1023];
    logic log_write [0:1023];
    logic req_q;
    logic ack_q;

    mcu_bridge mcu_bridge_i (
        .clk(clk),
        .reset(reset),
        .mcu_clk(mcu_clk),
        .mcu_cs(mcu_cs),
        .mcu_mosi(mcu_mosi),
        .mcu_miso(mcu_miso),
        .sd_det(sd_det),
        .button(button),
        .mem_request(mem_request),
        .mem_ack(mem_ack),
        .mem_write(mem_write),
        .mem_address(mem_address),
        .mem_wdata(mem_wdata),
        .mem_rdata(mem_rdata)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    function automatic logic [31:0] lcg_step(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic mem_word_t fill_word(input logic [31:0] address);
        return address[31:16] ^ address[15:0] ^ 16'ha5c3;
    endfunction

    function automatic mem_word_t model_word(input logic [31:0] address);
        if (mem_valid[address[10:1]] && mem_owner[address[10:1]] == address) begin
            return mem_model[address[10:1]];
        end
        return fill_word(address);
    endfunction

    function automatic reg_word_t control_word(input int length, input logic write,
                                               input logic start, input logic stop);
        reg_word_t word;
        word = '0;
        word[`MEM_SCR_LEN_MSB:`MEM_SCR_LEN_LSB] = length[9:0];
        word[`MEM_SCR_DIR] = write;
        word[`MEM_SCR_START] = start;
        word[`MEM_SCR_STOP] = stop;
        return word;
    endfunction

    task automatic expect_equal(input string name, input logic [31:0] got,
                                input logic [31:0] expected);
        checks++;
        assert (got === expected) else begin
            errors++;
            $display("FAILED %s: got %h, expected %h", name, got, expected);
        end
    endtask

    // ============================================================
    // SPI master
    // ============================================================

    task automatic spi_byte(input logic [7:0] tx, output logic [7:0] rx);
        for (int i = 7; i >= 0; i--) begin
            mcu_mosi <= tx[i];   // changes with the falling edge
            repeat (HALF) @(posedge clk);
            mcu_clk <= 1'b1;
            rx[i] = mcu_miso;
            repeat (HALF) @(posedge clk);
            mcu_clk <= 1'b0;
        end
    endtask

    task automatic frame_begin();
        mcu_cs <= 1'b0;
        repeat (HALF) @(posedge clk);
    endtask

    task automatic frame_end();
        repeat (HALF) @(posedge clk);
        mcu_cs <= 1'b1;
        repeat (HALF) @(posedge clk);
    endtask

    task automatic send_header(input logic [7:0] cmd, input logic [7:0] address);
        logic [7:0] rx;
        frame_begin();
        spi_byte(cmd, rx);
        spi_byte(address, rx);
    endtask

    task automatic write_register(input logic [7:0] address, input reg_word_t data);
        logic [7:0] rx;
        send_header(CMD_REG_WRITE, address);
        for (int b = 0; b < 4; b++) begin
            spi_byte(data[8*b +: 8], rx);   // lsb first
        end
        frame_end();
    endtask

    task automatic read_registers(input logic [7:0] address, input int count);
        logic [7:0] rx;
        send_header(CMD_REG_READ, address);
        for (int w = 0; w < count; w++) begin
            for (int b = 0; b < 4; b++) begin
                spi_byte(8'h00, rx);
                reg_words[w][8*b +: 8] = rx;
            end
        end
        frame_end();
    endtask

    task automatic write_buffer(input logic [7:0] address, input int count);
        logic [7:0] rx;
        send_header(CMD_BUF_WRITE, address);
        for (int w = 0; w < count; w++) begin
            spi_byte(word_data[w][15:8], rx);
            spi_byte(word_data[w][7:0], rx);
        end
        frame_end();
    endtask

    task automatic read_buffer(input logic [7:0] address, input int count);
        logic [7:0] high;
        logic [7:0] low;
        send_header(CMD_BUF_READ, address);
        for (int w = 0; w < count; w++) begin
            spi_byte(8'h00, high);
            spi_byte(8'h00, low);
            word_read[w] = {high, low};
        end
        frame_end();
    endtask

    task automatic wait_idle();
        int polls;
        polls = 0;
        read_registers(REG_MEM_SCR, 1);
        while (reg_words[0][`MEM_SCR_BUSY] !== 1'b0 && polls < POLL_LIMIT) begin
            polls++;
            read_registers(REG_MEM_SCR, 1);
        end
        if (reg_words[0][`MEM_SCR_BUSY] !== 1'b0) begin
            timeouts++;
            $display("timeout: transfer still busy after %0d status reads", polls);
        end
    endtask

    task automatic wait_first_ack(input int first);
        int cycles;
        cycles = 0;
        while (req_count <= first && cycles < ACK_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (req_count <= first) begin
            timeouts++;
            $display("timeout: no memory ack after %0d cycles", cycles);
        end
    endtask

    // ============================================================
    // memory bus model
    // ============================================================

    always begin : memory_model
        int delay;
        logic [31:0] address;
        mem_word_t data;
        logic write;
        @(posedge clk);
        if (!reset && mem_request === 1'b1) begin
            address = mem_address;
            data = mem_wdata;
            write = mem_write;
            delay_state = lcg_step(delay_state);
            delay = int'(delay_state[23:16]) % 6;
            repeat (delay) begin
                @(posedge clk);
                expect_equal("mem_request", mem_request, 1'b1);
            end
            expect_equal("mem_address", mem_address, address);
            expect_equal("mem_wdata", mem_wdata, data);
            if (write) begin
                mem_model[address[10:1]] = data;
                mem_owner[address[10:1]] = address;
                mem_valid[address[10:1]] = 1'b1;
            end else begin
                mem_rdata <= model_word(address);
            end
            if (req_count < 1024) begin
                log_address[req_count] = address;
                log_data[req_count] = data;
                log_write[req_count] = write;
            end
            req_count++;
            mem_ack <= 1'b1;
            @(posedge clk);
            mem_ack <= 1'b0;
        end
    end

    // a request may only fall after an ack
    always @(posedge clk) begin
        if (!reset && req_q === 1'b1 && mem_request === 1'b0) begin
            expect_equal("mem_ack before request drop", ack_q, 1'b1);
        end
        req_q <= mem_request;
        ack_q <= mem_ack;
    end

    // ============================================================
    // test sequence
    // ============================================================

    initial begin
        reg_word_t value;
        logic [31:0] base;
        logic [7:0] start;
        logic [7:0] rx;
        int first;
        int moved;

        checks = 0;
        errors = 0;
        timeouts = 0;
        req_count = 0;
        stim_state = 32'h9ea6;
        delay_state = 32'h9ea6;
        for (int i = 0; i < 1024; i++) begin
            mem_valid[i] = 1'b0;
        end
        reset = 1'b1;
        mcu_clk = 1'b0;
        mcu_cs = 1'b1;
        mcu_mosi = 1'b0;
        sd_det = 1'b1;
        button = 1'b1;
        mem_ack = 1'b0;
        mem_rdata = '0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        repeat (2) @(posedge clk);

        // identify
        frame_begin();
        spi_byte(CMD_IDENTIFY, rx);
        for (int i = 0; i < 3; i++) begin
            spi_byte(8'h00, rx);
            expect_equal("mcu_miso identify byte", rx, `MCU_FPGA_ID);
        end
        frame_end();
        read_registers(REG_IDENTIFIER, 1);
        expect_equal("identifier register", reg_words[0], `MCU_CHIP_ID);

        // register access and auto-increment
        stim_state = lcg_step(stim_state);
        value = stim_state;
        write_register(REG_MEM_ADDRESS, value);
        read_registers(REG_MEM_ADDRESS, 2);
        expect_equal("memory address register", reg_words[0], value);
        expect_equal("busy bit when idle", reg_words[1][`MEM_SCR_BUSY], 1'b0);
        for (int i = 0; i < 4; i++) begin
            button <= i[0];
            sd_det <= i[1];
            repeat (`SYNC_STAGES + 1) @(posedge clk);   // settle
            read_registers(REG_INPUT_STATUS, 1);
            expect_equal("input status", reg_words[0][1:0], {~i[0], ~i[1]});
        end

        // buffer access
        stim_state = lcg_step(stim_state);
        start = {1'b0, stim_state[22:16]};
        for (int i = 0; i < 6; i++) begin
            stim_state = lcg_step(stim_state);
            word_data[i] = stim_state[31:16];
        end
        write_buffer(start, 6);
        read_buffer(start, 6);
        for (int i = 0; i < 6; i++) begin
            expect_equal("buffer word", word_read[i], word_data[i]);
        end

        // memory write
        stim_state = lcg_step(stim_state);
        base = {8'h01, stim_state[23:8], 8'h00};
        write_register(REG_MEM_ADDRESS, base);
        for (int i = 0; i < WRITE_WORDS; i++) begin
            stim_state = lcg_step(stim_state);
            word_data[i] = stim_state[31:16];
        end
        write_buffer(8'd0, WRITE_WORDS);
        first = req_count;
        write_register(REG_MEM_SCR, control_word(WRITE_WORDS, 1'b1, 1'b1, 1'b0));
        read_registers(REG_MEM_SCR, 1);
        expect_equal("busy bit during transfer", reg_words[0][`MEM_SCR_BUSY], 1'b1);
        expect_equal("requests still pending", (req_count - first) < WRITE_WORDS, 1'b1);
        wait_idle();
        expect_equal("write request count", req_count - first, WRITE_WORDS);
        for (int i = 0; i < WRITE_WORDS; i++) begin
            expect_equal("mem_address", log_address[first + i], base + 2 * i);
            expect_equal("mem_wdata", log_data[first + i], word_data[i]);
            expect_equal("mem_write", log_write[first + i], 1'b1);
        end

        // memory read
        base = base + 32'h0001_0000;   // region never written
        write_register(REG_MEM_ADDRESS, base);
        first = req_count;
        write_register(REG_MEM_SCR, control_word(READ_WORDS, 1'b0, 1'b1, 1'b0));
        wait_idle();
        expect_equal("read request count", req_count - first, READ_WORDS);
        read_buffer(8'd0, READ_WORDS);
        for (int i = 0; i < READ_WORDS; i++) begin
            expect_equal("buffer word after read", word_read[i], model_word(base + 2 * i));
        end

        // stopped transfer
        first = req_count;
        write_register(REG_MEM_SCR, control_word(STOP_WORDS, 1'b0, 1'b1, 1'b0));
        wait_first_ack(first);
        write_register(REG_MEM_SCR, control_word(STOP_WORDS, 1'b0, 1'b0, 1'b1));
        wait_idle();
        moved = req_count - first;
        expect_equal("busy bit after stop", reg_words[0][`MEM_SCR_BUSY], 1'b0);
        expect_equal("words moved before stop", moved > 0 && moved < STOP_WORDS, 1'b1);

        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
